// File: tb.f
rtl/pma_pkg.sv
rtl/pma_region_table.sv
rtl/access_issuer.sv
rtl/access_fifo.sv
rtl/access_checker.sv
rtl/pma_unit.sv
dv/tb_pma_unit.sv

// File: Makefile
# Verilator build and run for the PMA checker testbench

VERILATOR ?= verilator
TOP ?= tb_pma_unit
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_pma_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pma_unit
	import pma_pkg::*;
();

	localparam int FIFO_DEPTH = 4;
	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DLY = 1;
	localparam int RESET_CYCLES = 16;
	localparam int SEED = 74458;
	localparam int STREAM_LEN = 200;
	// Rough cycle budget summed over the tests
	// The random stream dominates
	localparam int TEST_CYCLES = RESET_CYCLES + 90 + 30 + 30 + 60 + 50 + STREAM_LEN * 8;
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [REGION_W-1:0] region;
		logic hit;
		logic allowed;
	} result_t;

	logic clk;
	logic arst_n;
	logic req_valid;
	logic req_ready;
	logic [ADDR_W-1:0] req_addr;
	access_kind_t req_kind;
	logic [TAG_W-1:0] req_tag;
	logic cfg_wr;
	logic [CFG_ADDR_W-1:0] cfg_addr;
	logic [DATA_W-1:0] cfg_wdata;
	logic [DATA_W-1:0] cfg_rdata;
	logic res_valid;
	logic res_ready;
	logic [TAG_W-1:0] res_tag;
	logic [REGION_W-1:0] res_region;
	logic res_hit;
	logic res_allowed;

	// Reference table and expected results in request order
	logic [31:0] m_start [8];
	logic [31:0] m_end [8];
	logic [31:0] m_attr [8];
	logic [31:0] m_lock [8];
	result_t exp_q [$];
	logic [TAG_W-1:0] next_tag;
	int checks;
	int errors;

	pma_unit #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_pma_unit (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_addr(req_addr),
		.req_kind(req_kind),
		.req_tag(req_tag),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_tag(res_tag),
		.res_region(res_region),
		.res_hit(res_hit),
		.res_allowed(res_allowed)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ==========================================================================
	// Reference model
	// ==========================================================================

	// Attribute layout is type in [7:4], cacheable in [3], x w r in [2:0]
	function automatic void model_reset();
		for (int i = 0; i < 8; i++) begin
			m_start[i] = 32'hFFFF_FFFF;
			m_end[i] = 32'hFFFF_FFFF;
			m_attr[i] = 32'h0;
			m_lock[i] = LOCK_CODE;
		end
		// DRAM
		m_start[1] = 32'h0000_0000;
		m_end[1] = 32'h1FFF_FFFF;
		m_attr[1] = 32'h1F;
		// Scratchpad
		m_start[4] = 32'hFFFC_0000;
		m_end[4] = 32'hFFFC_FFFF;
		m_attr[4] = 32'h17;
		// I/O
		m_start[6] = 32'hFF80_0000;
		m_end[6] = 32'hFF9F_FFFF;
		m_attr[6] = 32'h33;
		// ROM
		m_start[7] = 32'hFFFD_0000;
		m_end[7] = 32'hFFFF_FFFF;
		m_attr[7] = 32'h2D;
	endfunction

	function automatic void model_write(input logic [2:0] r, input logic [3:0] idx,
		input logic [31:0] data);
		// Locked region only takes its lock register
		if (m_lock[r] != UNLOCK_CODE && idx != REG_LOCK)
			return;
		case (idx)
			REG_START: m_start[r] = data;
			REG_END: m_end[r] = data;
			REG_ATTR: m_attr[r] = data;
			REG_LOCK: m_lock[r] = data;
			default: ;
		endcase
	endfunction

	function automatic logic [31:0] model_read(input logic [2:0] r, input logic [3:0] idx);
		case (idx)
			REG_START: return m_start[r];
			REG_END: return m_end[r];
			REG_ATTR: return m_attr[r];
			REG_LOCK: return m_lock[r];
			default: return 32'h0;
		endcase
	endfunction

	function automatic result_t predict(input logic [31:0] addr, input logic [1:0] kind,
		input logic [TAG_W-1:0] tag);
		result_t r;
		logic perm;
		r = '0;
		r.tag = tag;
		perm = 1'b0;
		// Highest matching region wins
		for (int i = 0; i < 8; i++) begin
			if (addr[31:GRAIN_LSB] >= m_start[i][31:GRAIN_LSB] &&
				addr[31:GRAIN_LSB] <= m_end[i][31:GRAIN_LSB]) begin
				r.hit = 1'b1;
				r.region = REGION_W'(i);
				case (kind)
					2'd0: perm = m_attr[i][0];
					2'd1: perm = m_attr[i][1];
					2'd2: perm = m_attr[i][2];
					default: perm = 1'b0;
				endcase
			end
		end
		r.allowed = r.hit && perm;
		return r;
	endfunction

	// ==========================================================================
	// Driver and checker helpers
	// ==========================================================================

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic cfg_write(input logic [2:0] r, input logic [3:0] idx, input logic [31:0] data);
		cfg_wr = 1'b1;
		cfg_addr = {r, idx};
		cfg_wdata = data;
		@(posedge clk);
		#DRIVE_DLY;
		cfg_wr = 1'b0;
		model_write(r, idx, data);
	endtask

	// Readback is valid one edge after the address is sampled
	task automatic cfg_read_check(input logic [2:0] r, input logic [3:0] idx);
		string name;
		cfg_addr = {r, idx};
		@(posedge clk);
		@(negedge clk);
		name = $sformatf("cfg_rdata region %0d reg %0d", r, idx);
		check_value(name, cfg_rdata, model_read(r, idx));
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic send_req(input logic [31:0] addr, input logic [1:0] kind);
		req_valid = 1'b1;
		req_addr = addr;
		req_kind = access_kind_t'(kind);
		req_tag = next_tag;
		@(negedge clk);
		while (!req_ready) begin
			@(posedge clk);
			@(negedge clk);
		end
		// Accepted on the coming edge
		exp_q.push_back(predict(addr, kind, next_tag));
		next_tag = next_tag + 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		req_valid = 1'b0;
	endtask

	task automatic drain_results();
		res_ready = 1'b1;
		while (exp_q.size() != 0)
			@(posedge clk);
		@(negedge clk);
		check_value("res_valid after drain", res_valid, 32'h0);
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// Result monitor samples mid-cycle where everything is settled
	always @(negedge clk) begin
		result_t e;
		if (arst_n && res_valid && res_ready) begin
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("Result with tag %h arrived with no request outstanding", res_tag);
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				check_value("res_tag", res_tag, e.tag);
				check_value("res_region", res_region, e.region);
				check_value("res_hit", res_hit, e.hit);
				check_value("res_allowed", res_allowed, e.allowed);
			end
		end
	end

	// ==========================================================================
	// Tests
	// ==========================================================================

	task automatic reset_defaults_test();
		for (int r = 0; r < 8; r++) begin
			cfg_read_check(3'(r), REG_START);
			cfg_read_check(3'(r), REG_END);
			cfg_read_check(3'(r), REG_ATTR);
			cfg_read_check(3'(r), REG_LOCK);
		end
		// Unmapped index
		cfg_read_check(3'd1, 4'd4);
		send_req(32'h0000_1000, ACC_READ);
		send_req(32'hFFFE_0000, ACC_READ);
		// ROM write is denied
		send_req(32'hFFFD_0040, ACC_WRITE);
		drain_results();
	endtask

	task automatic lock_rule_test();
		cfg_write(3'd2, REG_START, 32'h1000_0000);
		cfg_read_check(3'd2, REG_START);
		cfg_write(3'd2, REG_LOCK, UNLOCK_CODE);
		cfg_write(3'd2, REG_START, 32'h1000_0000);
		cfg_write(3'd2, REG_END, 32'h1000_FFFF);
		cfg_read_check(3'd2, REG_START);
		cfg_read_check(3'd2, REG_END);
		cfg_read_check(3'd2, REG_LOCK);
	endtask

	task automatic region_match_test();
		// Read-write RAM inside DRAM
		cfg_write(3'd2, REG_ATTR, 32'h13);
		cfg_read_check(3'd2, REG_ATTR);
		send_req(32'h1000_8000, ACC_READ);
		send_req(32'h1000_8000, ACC_EXEC);
		// Gap between DRAM and I/O
		send_req(32'h4000_0000, ACC_READ);
		drain_results();
	endtask

	task automatic permission_test();
		// Execute and write without read
		cfg_write(3'd2, REG_ATTR, 32'h16);
		for (int k = 0; k < 4; k++) begin
			send_req(32'hFF80_1000, 2'(k));
			send_req(32'hFFFE_8000, 2'(k));
			send_req(32'h1000_0040, 2'(k));
		end
		drain_results();
	endtask

	task automatic backpressure_test();
		int accepted;
		logic taken;
		accepted = 0;
		res_ready = 1'b0;
		req_valid = 1'b1;
		req_kind = ACC_READ;
		req_addr = 32'h0000_0100;
		req_tag = next_tag;
		for (int c = 0; c < 4 * FIFO_DEPTH + 8; c++) begin
			@(negedge clk);
			taken = req_ready;
			if (taken) begin
				exp_q.push_back(predict(req_addr, 2'd0, req_tag));
				accepted++;
			end
			@(posedge clk);
			#DRIVE_DLY;
			if (taken) begin
				next_tag = next_tag + 1'b1;
				req_tag = next_tag;
				req_addr = req_addr + 32'h10;
			end
		end
		check_value("accepted count", accepted, FIFO_DEPTH + 1);
		check_value("req_ready under back-pressure", req_ready, 32'h0);
		req_valid = 1'b0;
		drain_results();
	endtask

	task automatic random_stream_test();
		logic [31:0] bounds [7];
		logic [31:0] addr;
		bit done;
		// Region edges including the reprogrammed region 2
		bounds = '{32'h1000_0000, 32'h1001_0000, 32'h2000_0000, 32'hFF80_0000,
			32'hFFA0_0000, 32'hFFFC_0000, 32'hFFFD_0000};
		done = 1'b0;
		fork
			begin
				for (int n = 0; n < STREAM_LEN; n++) begin
					addr = bounds[$urandom_range(6)] + 32'($urandom_range(127)) - 32'd64;
					send_req(addr, 2'($urandom_range(3)));
				end
				done = 1'b1;
			end
			begin
				while (!done) begin
					res_ready = 1'($urandom_range(1));
					@(posedge clk);
					#DRIVE_DLY;
				end
			end
		join
		drain_results();
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		arst_n = 1'b0;
		req_valid = 1'b0;
		req_addr = '0;
		req_kind = ACC_READ;
		req_tag = '0;
		cfg_wr = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		res_ready = 1'b0;
		next_tag = '0;
		checks = 0;
		errors = 0;
		model_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		arst_n = 1'b1;
		res_ready = 1'b1;
		reset_defaults_test();
		lock_rule_test();
		region_match_test();
		permission_test();
		backpressure_test();
		random_stream_test();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/pma_unit.sv
`timescale 1ns/100ps
`default_nettype none

module pma_unit
	import pma_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input wire clk,
	input wire arst_n,
	// Requests
	input wire req_valid,
	output logic req_ready,
	input wire [ADDR_W-1:0] req_addr,
	input wire access_kind_t req_kind,
	input wire [TAG_W-1:0] req_tag,
	// Configuration
	input wire cfg_wr,
	input wire [CFG_ADDR_W-1:0] cfg_addr,
	input wire [DATA_W-1:0] cfg_wdata,
	output logic [DATA_W-1:0] cfg_rdata,
	// Results
	output logic res_valid,
	input wire res_ready,
	output logic [TAG_W-1:0] res_tag,
	output logic [REGION_W-1:0] res_region,
	output logic res_hit,
	output logic res_allowed
);

	// Issuer to FIFO
	logic push;
	logic [ADDR_W-1:0] push_addr;
	access_kind_t push_kind;
	logic [TAG_W-1:0] push_tag;

	// FIFO to checker
	logic fifo_empty;
	logic [ADDR_W-1:0] head_addr;
	access_kind_t head_kind;
	logic [TAG_W-1:0] head_tag;
	logic pop;
	logic credit_return;

	// Credits start at the FIFO size
	access_issuer #(
		.INIT_CREDITS(FIFO_DEPTH)
	) u_issuer (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_addr(req_addr),
		.req_kind(req_kind),
		.req_tag(req_tag),
		.credit_return(credit_return),
		.push(push),
		.push_addr(push_addr),
		.push_kind(push_kind),
		.push_tag(push_tag)
	);

	access_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.push(push),
		.push_addr(push_addr),
		.push_kind(push_kind),
		.push_tag(push_tag),
		.pop(pop),
		.empty(fifo_empty),
		.head_addr(head_addr),
		.head_kind(head_kind),
		.head_tag(head_tag)
	);

	access_checker u_checker (
		.clk(clk),
		.arst_n(arst_n),
		.fifo_empty(fifo_empty),
		.head_addr(head_addr),
		.head_kind(head_kind),
		.head_tag(head_tag),
		.pop(pop),
		.credit_return(credit_return),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res_tag(res_tag),
		.res_region(res_region),
		.res_hit(res_hit),
		.res_allowed(res_allowed)
	);

endmodule

`default_nettype wire

// File: rtl/access_checker.sv
`timescale 1ns/100ps
`default_nettype none

module access_checker
	import pma_pkg::*;
(
	input wire clk,
	input wire arst_n,
	// FIFO read side
	input wire fifo_empty,
	input wire [ADDR_W-1:0] head_addr,
	input wire access_kind_t head_kind,
	input wire [TAG_W-1:0] head_tag,
	output logic pop,
	output logic credit_return,
	// Configuration port, served by the region table
	input wire cfg_wr,
	input wire [CFG_ADDR_W-1:0] cfg_addr,
	input wire [DATA_W-1:0] cfg_wdata,
	output logic [DATA_W-1:0] cfg_rdata,
	// Result port
	output logic res_valid,
	input wire res_ready,
	output logic [TAG_W-1:0] res_tag,
	output logic [REGION_W-1:0] res_region,
	output logic res_hit,
	output logic res_allowed
);

	logic hit;
	logic [REGION_W-1:0] region_num;
	pma_attr_t region_attr;
	logic perm;
	logic allowed;

	pma_region_table u_region_table (
		.clk(clk),
		.arst_n(arst_n),
		.cfg_wr(cfg_wr),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.lookup_addr(head_addr),
		.hit(hit),
		.region_num(region_num),
		.region_attr(region_attr)
	);

	// Pop when an entry waits and the result slot is free or draining
	assign pop = !fifo_empty && (!res_valid || res_ready);
	// Each pop frees one FIFO slot
	assign credit_return = pop;

	// Permission bit for the access kind
	always_comb begin
		case (head_kind)
			ACC_READ: perm = region_attr.fields.r;
			ACC_WRITE: perm = region_attr.fields.w;
			ACC_EXEC: perm = region_attr.fields.x;
			// Reserved kind
			default: perm = 1'b0;
		endcase
	end

	assign allowed = hit && perm;

	// Result slot, loaded on the pop edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			res_valid <= 1'b0;
		else if (pop)
			res_valid <= 1'b1;
		else if (res_ready)
			res_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			res_tag <= head_tag;
			res_region <= region_num;
			res_hit <= hit;
			res_allowed <= allowed;
		end
	end

endmodule

`default_nettype wire

// File: rtl/access_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module access_fifo
	import pma_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
) (
	input wire clk,
	input wire arst_n,
	// Write side
	input wire push,
	input wire [ADDR_W-1:0] push_addr,
	input wire access_kind_t push_kind,
	input wire [TAG_W-1:0] push_tag,
	// Read side
	input wire pop,
	output logic empty,
	output logic [ADDR_W-1:0] head_addr,
	output access_kind_t head_kind,
	output logic [TAG_W-1:0] head_tag
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// Entry storage
	logic [ADDR_W-1:0] addr_mem [FIFO_DEPTH];
	access_kind_t kind_mem [FIFO_DEPTH];
	logic [TAG_W-1:0] tag_mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Wrap at FIFO_DEPTH, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// No full check, the issuer's credits bound occupancy
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			addr_mem[wr_ptr] <= push_addr;
			kind_mem[wr_ptr] <= push_kind;
			tag_mem[wr_ptr] <= push_tag;
		end
	end

	// Head entry is visible right after the pushing edge
	assign empty = (count == '0);
	assign head_addr = addr_mem[rd_ptr];
	assign head_kind = kind_mem[rd_ptr];
	assign head_tag = tag_mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/access_issuer.sv
`timescale 1ns/100ps
`default_nettype none

module access_issuer
	import pma_pkg::*;
#(
	parameter int INIT_CREDITS = 4
) (
	input wire clk,
	input wire arst_n,
	// Request side
	input wire req_valid,
	output logic req_ready,
	input wire [ADDR_W-1:0] req_addr,
	input wire access_kind_t req_kind,
	input wire [TAG_W-1:0] req_tag,
	// Credit back from the checker
	input wire credit_return,
	// FIFO write side
	output logic push,
	output logic [ADDR_W-1:0] push_addr,
	output access_kind_t push_kind,
	output logic [TAG_W-1:0] push_tag
);

	localparam int CNT_W = $clog2(INIT_CREDITS + 1);

	logic [CNT_W-1:0] credits;
	logic accept;

	// Ready depends on credits only, never on FIFO state
	assign req_ready = (credits != '0);
	assign accept = req_valid && req_ready;

	// Take on accept, give back on credit_return, both may hit together
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= CNT_W'(INIT_CREDITS);
		end else begin
			case ({accept, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ;
			endcase
		end
	end

	// One stage between request port and FIFO
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			push <= 1'b0;
		else
			push <= accept;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			push_addr <= req_addr;
			push_kind <= req_kind;
			push_tag <= req_tag;
		end
	end

endmodule

`default_nettype wire

// File: rtl/pma_region_table.sv
`timescale 1ns/100ps
`default_nettype none

module pma_region_table
	import pma_pkg::*;
(
	input wire clk,
	input wire arst_n,
	// Configuration port
	input wire cfg_wr,
	input wire [CFG_ADDR_W-1:0] cfg_addr,
	input wire [DATA_W-1:0] cfg_wdata,
	output logic [DATA_W-1:0] cfg_rdata,
	// Lookup port
	input wire [ADDR_W-1:0] lookup_addr,
	output logic hit,
	output logic [REGION_W-1:0] region_num,
	output pma_attr_t region_attr
);

	// Build an attribute word through the fields view
	function automatic logic [DATA_W-1:0] attr_word(
		input logic [3:0] mtype,
		input logic cache,
		input logic x,
		input logic w,
		input logic r
	);
		pma_attr_t a;
		a.raw = '0;
		a.fields.mtype = mtype;
		a.fields.cache = cache;
		a.fields.x = x;
		a.fields.w = w;
		a.fields.r = r;
		return a.raw;
	endfunction

	// ==========================================================================
	// Reset contents, region 0 first
	// ==========================================================================

	// Vacant regions sit at the very top with no permissions
	localparam logic [ADDR_W-1:0] DEF_START [REGION_COUNT] = '{
		32'hFFFF_FFFF,
		32'h0000_0000,	// DRAM
		32'hFFFF_FFFF,
		32'hFFFF_FFFF,
		32'hFFFC_0000,	// Scratchpad
		32'hFFFF_FFFF,
		32'hFF80_0000,	// I/O
		32'hFFFD_0000	// ROM
	};

	localparam logic [ADDR_W-1:0] DEF_END [REGION_COUNT] = '{
		32'hFFFF_FFFF,
		32'h1FFF_FFFF,
		32'hFFFF_FFFF,
		32'hFFFF_FFFF,
		32'hFFFC_FFFF,
		32'hFFFF_FFFF,
		32'hFF9F_FFFF,
		32'hFFFF_FFFF
	};

	// Type, cacheable, x, w, r
	localparam logic [DATA_W-1:0] DEF_ATTR [REGION_COUNT] = '{
		attr_word(MT_NONE, 1'b0, 1'b0, 1'b0, 1'b0),
		attr_word(MT_RAM, 1'b1, 1'b1, 1'b1, 1'b1),
		attr_word(MT_NONE, 1'b0, 1'b0, 1'b0, 1'b0),
		attr_word(MT_NONE, 1'b0, 1'b0, 1'b0, 1'b0),
		attr_word(MT_RAM, 1'b0, 1'b1, 1'b1, 1'b1),
		attr_word(MT_NONE, 1'b0, 1'b0, 1'b0, 1'b0),
		attr_word(MT_IO, 1'b0, 1'b0, 1'b1, 1'b1),
		attr_word(MT_ROM, 1'b1, 1'b1, 1'b0, 1'b1)
	};

	logic [ADDR_W-1:0] start_q [REGION_COUNT];
	logic [ADDR_W-1:0] end_q [REGION_COUNT];
	pma_attr_t attr_q [REGION_COUNT];
	logic [DATA_W-1:0] lock_q [REGION_COUNT];

	logic [REGION_W-1:0] cfg_sel;
	logic [3:0] cfg_reg;
	logic wr_ok;
	logic [ADDR_W-GRAIN_LSB-1:0] grain_addr;

	// Split config address into region and register
	assign cfg_sel = cfg_addr[CFG_ADDR_W-1:4];
	assign cfg_reg = cfg_addr[3:0];

	// Locked regions only take writes to their lock register
	assign wr_ok = cfg_wr && (lock_q[cfg_sel] == UNLOCK_CODE || cfg_reg == REG_LOCK);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REGION_COUNT; i++) begin
				start_q[i] <= DEF_START[i];
				end_q[i] <= DEF_END[i];
				attr_q[i].raw <= DEF_ATTR[i];
				// Every region comes up locked
				lock_q[i] <= LOCK_CODE;
			end
		end else if (wr_ok) begin
			case (cfg_reg)
				REG_START: start_q[cfg_sel] <= cfg_wdata;
				REG_END: end_q[cfg_sel] <= cfg_wdata;
				REG_ATTR: attr_q[cfg_sel].raw <= cfg_wdata;
				REG_LOCK: lock_q[cfg_sel] <= cfg_wdata;
				default: ;
			endcase
		end
	end

	// Registered readback, unmapped indices return zero
	always_ff @(posedge clk) begin
		case (cfg_reg)
			REG_START: cfg_rdata <= start_q[cfg_sel];
			REG_END: cfg_rdata <= end_q[cfg_sel];
			REG_ATTR: cfg_rdata <= attr_q[cfg_sel].raw;
			REG_LOCK: cfg_rdata <= lock_q[cfg_sel];
			default: cfg_rdata <= '0;
		endcase
	end

	// ==========================================================================
	// Address lookup
	// ==========================================================================

	assign grain_addr = lookup_addr[ADDR_W-1:GRAIN_LSB];

	// Inclusive range compare, later regions override earlier ones
	always_comb begin
		hit = 1'b0;
		region_num = '0;
		region_attr.raw = '0;
		for (int i = 0; i < REGION_COUNT; i++) begin
			if (grain_addr >= start_q[i][ADDR_W-1:GRAIN_LSB] &&
				grain_addr <= end_q[i][ADDR_W-1:GRAIN_LSB]) begin
				hit = 1'b1;
				region_num = REGION_W'(i);
				region_attr = attr_q[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/pma_pkg.sv
`default_nettype none

package pma_pkg;

	// ==========================================================================
	// Widths
	// ==========================================================================

	// Physical address and configuration word
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	// Request tag carried through to the result
	localparam int TAG_W = 4;

	// Region count is tied to the 3-bit region field of cfg_addr
	localparam int REGION_COUNT = 8;
	localparam int REGION_W = $clog2(REGION_COUNT);

	// Config address: region in [6:4], register in [3:0]
	localparam int CFG_ADDR_W = 7;

	// Address bits below this are ignored in region compares (16 byte grain)
	localparam int GRAIN_LSB = 4;

	// ==========================================================================
	// Register map and lock words
	// ==========================================================================

	localparam logic [3:0] REG_START = 4'd0;
	localparam logic [3:0] REG_END = 4'd2;
	localparam logic [3:0] REG_ATTR = 4'd8;
	localparam logic [3:0] REG_LOCK = 4'd14;

	// ASCII lock words
	localparam logic [DATA_W-1:0] LOCK_CODE = "LOCK";
	localparam logic [DATA_W-1:0] UNLOCK_CODE = "UNLK";

	// Access kinds, code 3 is reserved and never allowed
	typedef enum logic [1:0] {
		ACC_READ = 2'd0,
		ACC_WRITE = 2'd1,
		ACC_EXEC = 2'd2
	} access_kind_t;

	// Memory type field values
	localparam logic [3:0] MT_NONE = 4'd0;
	localparam logic [3:0] MT_RAM = 4'd1;
	localparam logic [3:0] MT_ROM = 4'd2;
	localparam logic [3:0] MT_IO = 4'd3;

	// Attribute word, raw for config access, fields for the lookup
	typedef union packed {
		logic [DATA_W-1:0] raw;
		struct packed {
			logic [DATA_W-9:0] rsvd;
			logic [3:0] mtype;
			logic cache;
			logic x;
			logic w;
			logic r;
		} fields;
	} pma_attr_t;

endpackage

`default_nettype wire
